/* common/riscv_consts.svh */
// Width, shift-amount, PC step and register-count macros for the RV32I core

`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

`default_nettype none

// Data path width
`define XLEN 32

// Register index width and register count
`define REG_ADDR_W 5
`define NUM_REGS 32

// Shift amount taken from the low bits of operand 2
`define SHAMT_W 5

// PC increment per accepted instruction
`define PC_STEP 4

`default_nettype wire

`endif

/* common/riscvPkg.sv */
// RV32I core types: opcode and ALU enums, operand selects, forwarding selects
// Control structs and the instruction word union with R, I and U views
`include "riscv_consts.svh"
`default_nettype none

package riscvPkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcodeE;

    // ALU operations, PASS_B routes operand 2 straight through
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10
    } aluOpE;

    // Second-level operand selects
    typedef enum logic {SRC_RS1, SRC_PC} srcAE;
    typedef enum logic {SRC_RS2, SRC_IMM} srcBE;

    // First-level operand selects
    typedef enum logic [1:0] {NO_FWD, FWD_ALU, FWD_WB} fwdSelE;

    // Execute controls carried through ID/EX
    typedef struct packed {
        aluOpE aluOp;
        srcAE  srcA;
        srcBE  srcB;
    } exCtrlT;

    // Forwarding controls per operand
    typedef struct packed {
        fwdSelE fwdA;
        fwdSelE fwdB;
    } fwdCtrlT;

    // One instruction word, three decodings
    typedef union packed {
        struct packed {
            logic [6:0]             funct7;
            logic [`REG_ADDR_W-1:0] rs2;
            logic [`REG_ADDR_W-1:0] rs1;
            logic [2:0]             funct3;
            logic [`REG_ADDR_W-1:0] rd;
            opcodeE                 opcode;
        } rType;
        struct packed {
            logic [11:0]            imm12;
            logic [`REG_ADDR_W-1:0] rs1;
            logic [2:0]             funct3;
            logic [`REG_ADDR_W-1:0] rd;
            opcodeE                 opcode;
        } iType;
        struct packed {
            logic [19:0]            imm20;
            logic [`REG_ADDR_W-1:0] rd;
            opcodeE                 opcode;
        } uType;
    } instrWordU;

endpackage

`default_nettype wire

/* common/idExIf.sv */
// ID/EX bundle from decode to execute, writeback and forwarding
`include "riscv_consts.svh"
`default_nettype none

interface idExIf;

    // Valid marks a supported instruction in the stage
    logic                   valid;
    riscvPkg::exCtrlT       ctrl;

    // Register indices
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;

    // Operand payload
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       rs1Data;
    logic [`XLEN-1:0]       rs2Data;

    // Decode side fills the register
    modport stage (output valid, ctrl, rd, rs1, rs2, pc, imm, rs1Data, rs2Data);

    // Execute and writeback see operands and destination
    modport exec (input valid, ctrl, rd, pc, imm, rs1Data, rs2Data);

    // Forwarding compares the sources only
    modport fwd (input valid, rs1, rs2);

endinterface

`default_nettype wire

/* decode/regFile.sv */
// Register file, x0 fixed at zero, write data bypassed to reads
`include "riscv_consts.svh"
`default_nettype none

module regFile (
    input  logic                   CLK,
    input  logic                   rstN,
    input  logic [`REG_ADDR_W-1:0] rs1Addr,
    input  logic [`REG_ADDR_W-1:0] rs2Addr,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] wAddr,
    input  logic [`XLEN-1:0]       wData,
    output logic [`XLEN-1:0]       rs1Rd,
    output logic [`XLEN-1:0]       rs2Rd
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // Writes to x0 dropped
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wAddr != '0) begin
            regs[wAddr] <= wData;
        end
    end

    // Same-cycle write seen by the decoder
    always_comb begin
        if (rs1Addr == '0)                  rs1Rd = '0;
        else if (we && wAddr == rs1Addr)    rs1Rd = wData;
        else                                rs1Rd = regs[rs1Addr];

        if (rs2Addr == '0)                  rs2Rd = '0;
        else if (we && wAddr == rs2Addr)    rs2Rd = wData;
        else                                rs2Rd = regs[rs2Addr];
    end

endmodule

`default_nettype wire

/* decode/decodeStage.sv */
// Decode stage: control and immediate generation, PC tracking, ID/EX register
`include "riscv_consts.svh"
`default_nettype none

module decodeStage (
    input  logic                   CLK,
    input  logic                   rstN,
    input  logic                   instrValid,
    input  riscvPkg::instrWordU    instr,
    output logic [`REG_ADDR_W-1:0] rs1Addr,
    output logic [`REG_ADDR_W-1:0] rs2Addr,
    input  logic [`XLEN-1:0]       rs1Rd,
    input  logic [`XLEN-1:0]       rs2Rd,
    idExIf.stage                   idEx
);

    logic             decValid;
    riscvPkg::exCtrlT decCtrl;
    logic [`XLEN-1:0] decImm;
    logic [`XLEN-1:0] pc;

    // funct3 to ALU op, alt picks SUB or SRA
    function automatic riscvPkg::aluOpE funct3Op(input logic [2:0] funct3, input logic alt);
        riscvPkg::aluOpE op;
        case (funct3)
            3'b000:  op = alt ? riscvPkg::SUB : riscvPkg::ADD;
            3'b001:  op = riscvPkg::SLL;
            3'b010:  op = riscvPkg::SLT;
            3'b011:  op = riscvPkg::SLTU;
            3'b100:  op = riscvPkg::XOR;
            3'b101:  op = alt ? riscvPkg::SRA : riscvPkg::SRL;
            3'b110:  op = riscvPkg::OR;
            default: op = riscvPkg::AND;
        endcase
        return op;
    endfunction

    // Register file read addresses, same field positions in R and I forms
    assign rs1Addr = instr.rType.rs1;
    assign rs2Addr = instr.rType.rs2;

    always_comb begin
        decValid     = 1'b0;
        decCtrl      = '{aluOp: riscvPkg::ADD, srcA: riscvPkg::SRC_RS1, srcB: riscvPkg::SRC_RS2};
        decImm       = '0;
        case (instr.rType.opcode)
            riscvPkg::OP: begin
                decValid      = instrValid;
                decCtrl.aluOp = funct3Op(instr.rType.funct3, instr.rType.funct7[5]);
            end
            riscvPkg::OP_IMM: begin
                decValid      = instrValid;
                // No SUBI, only SRAI uses imm[10]
                decCtrl.aluOp = funct3Op(instr.iType.funct3,
                                         instr.iType.funct3 == 3'b101 && instr.iType.imm12[10]);
                decCtrl.srcB  = riscvPkg::SRC_IMM;
                decImm        = {{(`XLEN-12){instr.iType.imm12[11]}}, instr.iType.imm12};
            end
            riscvPkg::LUI: begin
                decValid      = instrValid;
                decCtrl.aluOp = riscvPkg::PASS_B;
                decCtrl.srcB  = riscvPkg::SRC_IMM;
                decImm        = {instr.uType.imm20, {(`XLEN-20){1'b0}}};
            end
            riscvPkg::AUIPC: begin
                decValid      = instrValid;
                decCtrl.srcA  = riscvPkg::SRC_PC;
                decCtrl.srcB  = riscvPkg::SRC_IMM;
                decImm        = {instr.uType.imm20, {(`XLEN-20){1'b0}}};
            end
            // Unsupported opcode stays invalid
            default: ;
        endcase
    end

    // Stage valid and PC
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            idEx.valid <= 1'b0;
            pc         <= '0;
        end else begin
            idEx.valid <= decValid;
            if (decValid) begin
                pc <= pc + `XLEN'(`PC_STEP);
            end
        end
    end

    // ID/EX payload, loaded only for accepted instructions
    always_ff @(posedge CLK) begin
        if (decValid) begin
            idEx.ctrl    <= decCtrl;
            idEx.rd      <= instr.rType.rd;
            idEx.rs1     <= instr.rType.rs1;
            idEx.rs2     <= instr.rType.rs2;
            idEx.pc      <= pc;
            idEx.imm     <= decImm;
            idEx.rs1Data <= rs1Rd;
            idEx.rs2Data <= rs2Rd;
        end
    end

endmodule

`default_nettype wire

/* execute/alu.sv */
// Combinational RV32I integer ALU
`include "riscv_consts.svh"
`default_nettype none

module alu (
    input  logic [`XLEN-1:0] op1,
    input  logic [`XLEN-1:0] op2,
    input  riscvPkg::aluOpE  aluOp,
    output logic [`XLEN-1:0] result
);

    logic [`SHAMT_W-1:0] shamt;
    logic                ltSigned;
    logic                ltUnsigned;

    // Shift count from low bits only
    assign shamt      = op2[`SHAMT_W-1:0];
    assign ltSigned   = $signed(op1) < $signed(op2);
    assign ltUnsigned = op1 < op2;

    always_comb begin
        case (aluOp)
            riscvPkg::ADD:    result = op1 + op2;
            riscvPkg::SUB:    result = op1 - op2;
            riscvPkg::SLL:    result = op1 << shamt;
            riscvPkg::SLT:    result = {{(`XLEN-1){1'b0}}, ltSigned};
            riscvPkg::SLTU:   result = {{(`XLEN-1){1'b0}}, ltUnsigned};
            riscvPkg::XOR:    result = op1 ^ op2;
            riscvPkg::SRL:    result = op1 >> shamt;
            // Arithmetic shift keeps the sign bit
            riscvPkg::SRA:    result = $unsigned($signed(op1) >>> shamt);
            riscvPkg::OR:     result = op1 | op2;
            riscvPkg::AND:    result = op1 & op2;
            // LUI result is the immediate itself
            riscvPkg::PASS_B: result = op2;
            default:          result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* execute/forwardUnit.sv */
// Forwarding select from the result and writeback stage destinations
`include "riscv_consts.svh"
`default_nettype none

module forwardUnit (
    idExIf.fwd                     idEx,
    input  logic                   aluValid,
    input  logic [`REG_ADDR_W-1:0] aluRd,
    input  logic                   wbValid,
    input  logic [`REG_ADDR_W-1:0] wbRd,
    output riscvPkg::fwdCtrlT      fwdCtrl
);

    // Result stage checked first, it holds the younger producer
    function automatic riscvPkg::fwdSelE pickSrc(
        input logic                   rs,
        input logic [`REG_ADDR_W-1:0] rsAddr,
        input logic                   aluHit,
        input logic [`REG_ADDR_W-1:0] aluDst,
        input logic                   wbHit,
        input logic [`REG_ADDR_W-1:0] wbDst
    );
        riscvPkg::fwdSelE sel;
        sel = riscvPkg::NO_FWD;
        // x0 never forwarded
        if (rs && rsAddr != '0) begin
            if (aluHit && aluDst == rsAddr) begin
                sel = riscvPkg::FWD_ALU;
            end else if (wbHit && wbDst == rsAddr) begin
                sel = riscvPkg::FWD_WB;
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwdCtrl.fwdA = pickSrc(idEx.valid, idEx.rs1, aluValid, aluRd, wbValid, wbRd);
        fwdCtrl.fwdB = pickSrc(idEx.valid, idEx.rs2, aluValid, aluRd, wbValid, wbRd);
    end

endmodule

`default_nettype wire

/* execute/execStage.sv */
// Execute stage: forwarding muxes, PC and immediate muxes, ALU
`include "riscv_consts.svh"
`default_nettype none

module execStage (
    idExIf.exec                    idEx,
    input  riscvPkg::fwdCtrlT      fwdCtrl,
    input  logic [`XLEN-1:0]       fwdAlu,
    input  logic [`XLEN-1:0]       fwdWb,
    output logic [`XLEN-1:0]       aluResult
);

    logic [`XLEN-1:0] muxAOut;
    logic [`XLEN-1:0] muxBOut;
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;

    alu alu_inst (
        .op1    (op1),
        .op2    (op2),
        .aluOp  (idEx.ctrl.aluOp),
        .result (aluResult)
    );

    always_comb begin
        // First level, register value or a forwarded result
        case (fwdCtrl.fwdA)
            riscvPkg::FWD_ALU: muxAOut = fwdAlu;
            riscvPkg::FWD_WB:  muxAOut = fwdWb;
            default:           muxAOut = idEx.rs1Data;
        endcase

        case (fwdCtrl.fwdB)
            riscvPkg::FWD_ALU: muxBOut = fwdAlu;
            riscvPkg::FWD_WB:  muxBOut = fwdWb;
            default:           muxBOut = idEx.rs2Data;
        endcase

        // Second level, PC for AUIPC
        case (idEx.ctrl.srcA)
            riscvPkg::SRC_PC: op1 = idEx.pc;
            default:          op1 = muxAOut;
        endcase

        // Immediate for OP-IMM, LUI, AUIPC
        case (idEx.ctrl.srcB)
            riscvPkg::SRC_IMM: op2 = idEx.imm;
            default:           op2 = muxBOut;
        endcase
    end

endmodule

`default_nettype wire

/* logic/writebackStage.sv */
// Result register and writeback register behind the execute stage
`include "riscv_consts.svh"
`default_nettype none

module writebackStage (
    input  logic                   CLK,
    input  logic                   rstN,
    idExIf.exec                    idEx,
    input  logic [`XLEN-1:0]       aluResult,
    output logic                   aluValid,
    output logic [`REG_ADDR_W-1:0] aluRd,
    output logic [`XLEN-1:0]       aluData,
    output logic                   wbValid,
    output logic [`REG_ADDR_W-1:0] wbRd,
    output logic [`XLEN-1:0]       wbData
);

    // Valid bits follow the instruction down the pipe
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            aluValid <= 1'b0;
            wbValid  <= 1'b0;
        end else begin
            aluValid <= idEx.valid;
            wbValid  <= aluValid;
        end
    end

    // Destination and data, qualified by the valid bits
    always_ff @(posedge CLK) begin
        aluRd   <= idEx.rd;
        aluData <= aluResult;
        wbRd    <= aluRd;
        wbData  <= aluData;
    end

endmodule

`default_nettype wire

/* logic/riscvCore.sv */
// RV32I core top: decode, register file, forwarding, execute, writeback
`include "riscv_consts.svh"
`default_nettype none

module riscvCore (
    input  logic                   CLK,
    input  logic                   rstN,
    input  logic                   instrValid,
    input  logic [`XLEN-1:0]       instr,
    output logic                   wbValid,
    output logic [`REG_ADDR_W-1:0] wbRd,
    output logic [`XLEN-1:0]       wbData
);

    riscvPkg::instrWordU    instrWord;
    riscvPkg::fwdCtrlT      fwdCtrl;
    logic [`REG_ADDR_W-1:0] rs1Addr;
    logic [`REG_ADDR_W-1:0] rs2Addr;
    logic [`XLEN-1:0]       rs1Rd;
    logic [`XLEN-1:0]       rs2Rd;
    logic [`XLEN-1:0]       aluResult;
    logic                   aluValid;
    logic [`REG_ADDR_W-1:0] aluRd;
    logic [`XLEN-1:0]       aluData;

    idExIf idEx ();

    // Raw word seen through the union views
    assign instrWord = instr;

    decodeStage decodeStage_inst (
        .CLK        (CLK),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instrWord),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .rs1Rd      (rs1Rd),
        .rs2Rd      (rs2Rd),
        .idEx       (idEx.stage)
    );

    // Written from the writeback register
    regFile regFile_inst (
        .CLK     (CLK),
        .rstN    (rstN),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .we      (wbValid),
        .wAddr   (wbRd),
        .wData   (wbData),
        .rs1Rd   (rs1Rd),
        .rs2Rd   (rs2Rd)
    );

    forwardUnit forwardUnit_inst (
        .idEx     (idEx.fwd),
        .aluValid (aluValid),
        .aluRd    (aluRd),
        .wbValid  (wbValid),
        .wbRd     (wbRd),
        .fwdCtrl  (fwdCtrl)
    );

    execStage execStage_inst (
        .idEx      (idEx.exec),
        .fwdCtrl   (fwdCtrl),
        .fwdAlu    (aluData),
        .fwdWb     (wbData),
        .aluResult (aluResult)
    );

    writebackStage writebackStage_inst (
        .CLK       (CLK),
        .rstN      (rstN),
        .idEx      (idEx.exec),
        .aluResult (aluResult),
        .aluValid  (aluValid),
        .aluRd     (aluRd),
        .aluData   (aluData),
        .wbValid   (wbValid),
        .wbRd      (wbRd),
        .wbData    (wbData)
    );

endmodule

`default_nettype wire

/* tb/tbRiscvCore.sv */
// RV32I core testbench with stimulus table, per-field compare tasks and watchdog
`include "riscv_consts.svh"
`default_nettype none

module tbRiscvCore;

    localparam int CLK_PERIOD  = 100;
    localparam int NUM_ENTRIES = 41;
    // Edges from instruction sample to writeback output
    localparam int PIPE_DEPTH  = 3;
    localparam int TIMEOUT     = (NUM_ENTRIES + 20) * CLK_PERIOD;

    logic                   CLK;
    logic                   rstN;
    logic                   instrValid;
    logic [`XLEN-1:0]       instr;
    logic                   wbValid;
    logic [`REG_ADDR_W-1:0] wbRd;
    logic [`XLEN-1:0]       wbData;

    // Stimulus and expected writeback per entry
    logic [`XLEN-1:0]       tblInstr    [NUM_ENTRIES];
    logic                   tblValid    [NUM_ENTRIES];
    logic                   tblExpValid [NUM_ENTRIES];
    logic [`REG_ADDR_W-1:0] tblExpRd    [NUM_ENTRIES];
    logic [`XLEN-1:0]       tblExpData  [NUM_ENTRIES];
    int                     tblCount;

    int validErrors;
    int rdErrors;
    int dataErrors;
    int otherErrors;

    riscvCore riscvCore_inst (
        .CLK        (CLK),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .wbValid    (wbValid),
        .wbRd       (wbRd),
        .wbData     (wbData)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // Instruction encoders for the three formats
    function automatic logic [`XLEN-1:0] encR(input logic [6:0] funct7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] funct3,
                                              input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, riscvPkg::OP};
    endfunction

    function automatic logic [`XLEN-1:0] encI(input logic [11:0] imm12, input logic [4:0] rs1,
                                              input logic [2:0] funct3, input logic [4:0] rd);
        return {imm12, rs1, funct3, rd, riscvPkg::OP_IMM};
    endfunction

    function automatic logic [`XLEN-1:0] encU(input riscvPkg::opcodeE opcode,
                                              input logic [19:0] imm20, input logic [4:0] rd);
        return {imm20, rd, opcode};
    endfunction

    task automatic addEntry(input logic [`XLEN-1:0] word, input logic valid,
                            input logic expValid, input logic [`REG_ADDR_W-1:0] expRd,
                            input logic [`XLEN-1:0] expData);
        tblInstr[tblCount]    = word;
        tblValid[tblCount]    = valid;
        tblExpValid[tblCount] = expValid;
        tblExpRd[tblCount]    = expRd;
        tblExpData[tblCount]  = expData;
        tblCount++;
    endtask

    // Program and expected writeback per instruction
    task automatic loadProgram();
        tblCount = 0;
        // Immediates and upper immediates
        addEntry(encI(12'd5, 5'd0, 3'b000, 5'd1), 1'b1, 1'b1, 5'd1, 32'h0000_0005);   // pc 0
        addEntry(encI(12'hFFD, 5'd0, 3'b000, 5'd2), 1'b1, 1'b1, 5'd2, 32'hFFFF_FFFD); // pc 4
        addEntry(encU(riscvPkg::LUI, 20'h12345, 5'd3), 1'b1, 1'b1, 5'd3, 32'h1234_5000);
        // AUIPC at pc 12
        addEntry(encU(riscvPkg::AUIPC, 20'h00001, 5'd4), 1'b1, 1'b1, 5'd4, 32'h0000_100C);
        addEntry(encI(12'h7FF, 5'd0, 3'b000, 5'd5), 1'b1, 1'b1, 5'd5, 32'h0000_07FF);
        addEntry(encI(12'h800, 5'd0, 3'b000, 5'd6), 1'b1, 1'b1, 5'd6, 32'hFFFF_F800);
        addEntry(encU(riscvPkg::LUI, 20'h80000, 5'd7), 1'b1, 1'b1, 5'd7, 32'h8000_0000);
        addEntry(encI(12'd3, 5'd0, 3'b000, 5'd8), 1'b1, 1'b1, 5'd8, 32'h0000_0003);   // pc 28
        // R-type set using x1 = 5, x2 = -3, x7 = 0x80000000 and x8 = 3
        addEntry(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd10), 1'b1, 1'b1, 5'd10, 32'h0000_0002);
        addEntry(encR(7'h20, 5'd2, 5'd1, 3'b000, 5'd11), 1'b1, 1'b1, 5'd11, 32'h0000_0008);
        addEntry(encR(7'h00, 5'd8, 5'd1, 3'b001, 5'd12), 1'b1, 1'b1, 5'd12, 32'h0000_0028);
        // Signed compare true and unsigned false
        addEntry(encR(7'h00, 5'd1, 5'd2, 3'b010, 5'd13), 1'b1, 1'b1, 5'd13, 32'h0000_0001);
        addEntry(encR(7'h00, 5'd1, 5'd2, 3'b011, 5'd14), 1'b1, 1'b1, 5'd14, 32'h0000_0000);
        addEntry(encR(7'h00, 5'd2, 5'd1, 3'b100, 5'd15), 1'b1, 1'b1, 5'd15, 32'hFFFF_FFF8);
        addEntry(encR(7'h00, 5'd8, 5'd7, 3'b101, 5'd16), 1'b1, 1'b1, 5'd16, 32'h1000_0000);
        addEntry(encR(7'h20, 5'd8, 5'd7, 3'b101, 5'd17), 1'b1, 1'b1, 5'd17, 32'hF000_0000);
        addEntry(encR(7'h00, 5'd8, 5'd1, 3'b110, 5'd18), 1'b1, 1'b1, 5'd18, 32'h0000_0007);
        addEntry(encR(7'h00, 5'd1, 5'd2, 3'b111, 5'd19), 1'b1, 1'b1, 5'd19, 32'h0000_0005);
        // SRAI by 1 and SLTIU against all ones
        addEntry(encI(12'h401, 5'd2, 3'b101, 5'd20), 1'b1, 1'b1, 5'd20, 32'hFFFF_FFFE);
        addEntry(encI(12'hFFF, 5'd1, 3'b011, 5'd21), 1'b1, 1'b1, 5'd21, 32'h0000_0001);
        // Forwarding distances on x9
        addEntry(encI(12'd10, 5'd0, 3'b000, 5'd9), 1'b1, 1'b1, 5'd9, 32'h0000_000A);
        addEntry(encI(12'd100, 5'd0, 3'b000, 5'd23), 1'b1, 1'b1, 5'd23, 32'h0000_0064);
        // Two ahead, then three ahead through the register file, then one ahead
        addEntry(encR(7'h00, 5'd8, 5'd9, 3'b000, 5'd22), 1'b1, 1'b1, 5'd22, 32'h0000_000D);
        addEntry(encI(12'd7, 5'd9, 3'b000, 5'd24), 1'b1, 1'b1, 5'd24, 32'h0000_0011);
        addEntry(encI(12'd1, 5'd24, 3'b000, 5'd25), 1'b1, 1'b1, 5'd25, 32'h0000_0012);
        // Younger of two x26 producers wins
        addEntry(encI(12'd1, 5'd0, 3'b000, 5'd26), 1'b1, 1'b1, 5'd26, 32'h0000_0001);
        addEntry(encI(12'd2, 5'd0, 3'b000, 5'd26), 1'b1, 1'b1, 5'd26, 32'h0000_0002);
        addEntry(encR(7'h00, 5'd26, 5'd26, 3'b000, 5'd27), 1'b1, 1'b1, 5'd27, 32'h0000_0004);
        // x0 destination still shows on the outputs
        addEntry(encI(12'd55, 5'd0, 3'b000, 5'd0), 1'b1, 1'b1, 5'd0, 32'h0000_0037);
        addEntry(encR(7'h00, 5'd0, 5'd0, 3'b000, 5'd28), 1'b1, 1'b1, 5'd28, 32'h0000_0000);
        addEntry(encI(12'd9, 5'd0, 3'b000, 5'd29), 1'b1, 1'b1, 5'd29, 32'h0000_0009);
        addEntry(encR(7'h00, 5'd1, 5'd0, 3'b000, 5'd30), 1'b1, 1'b1, 5'd30, 32'h0000_0005);
        // Bubble followed by load and store opcodes
        addEntry(encI(12'd1, 5'd0, 3'b000, 5'd31), 1'b0, 1'b0, 5'd0, 32'h0);
        addEntry(32'h0000_2083, 1'b1, 1'b0, 5'd0, 32'h0);
        addEntry(32'h0010_2023, 1'b1, 1'b0, 5'd0, 32'h0);
        // PC held at 128 over the three entries above
        addEntry(encU(riscvPkg::AUIPC, 20'h00000, 5'd31), 1'b1, 1'b1, 5'd31, 32'h0000_0080);
        addEntry(encU(riscvPkg::AUIPC, 20'h00001, 5'd31), 1'b0, 1'b0, 5'd0, 32'h0);
        addEntry(encU(riscvPkg::AUIPC, 20'h00002, 5'd31), 1'b1, 1'b1, 5'd31, 32'h0000_2084);
        addEntry(encI(12'd1, 5'd31, 3'b000, 5'd1), 1'b1, 1'b1, 5'd1, 32'h0000_2085);
        // Operand B dependency across a bubble
        addEntry(32'h0, 1'b0, 1'b0, 5'd0, 32'h0);
        addEntry(encR(7'h00, 5'd1, 5'd0, 3'b000, 5'd2), 1'b1, 1'b1, 5'd2, 32'h0000_2085);
    endtask

    task automatic checkValid(input int entry, input logic got, input logic exp);
        if (got !== exp) begin
            validErrors++;
            $display("Mismatch at %0t: entry %0d wbValid got %0b expected %0b",
                     $time, entry, got, exp);
        end
    endtask

    task automatic checkRd(input int entry, input logic [`REG_ADDR_W-1:0] got,
                           input logic [`REG_ADDR_W-1:0] exp);
        if (got !== exp) begin
            rdErrors++;
            $display("Mismatch at %0t: entry %0d wbRd got x%0d expected x%0d",
                     $time, entry, got, exp);
        end
    endtask

    task automatic checkData(input int entry, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            dataErrors++;
            $display("Mismatch at %0t: entry %0d wbData got 0x%08h expected 0x%08h",
                     $time, entry, got, exp);
        end
    endtask

    // Main sequence
    initial begin
        rstN        = 1'b0;
        instrValid  = 1'b0;
        instr       = '0;
        validErrors = 0;
        rdErrors    = 0;
        dataErrors  = 0;
        otherErrors = 0;
        loadProgram();
        if (tblCount != NUM_ENTRIES) begin
            otherErrors++;
            $display("Stimulus table holds %0d entries instead of %0d", tblCount, NUM_ENTRIES);
        end

        repeat (5) @(posedge CLK);
        @(negedge CLK);
        rstN = 1'b1;

        // Entry i goes in while entry i-3 comes out
        for (int i = 0; i < NUM_ENTRIES + PIPE_DEPTH; i++) begin
            @(negedge CLK);
            if (i >= PIPE_DEPTH) begin
                checkValid(i - PIPE_DEPTH, wbValid, tblExpValid[i - PIPE_DEPTH]);
                // Index and data only meaningful with valid set
                if (tblExpValid[i - PIPE_DEPTH]) begin
                    checkRd(i - PIPE_DEPTH, wbRd, tblExpRd[i - PIPE_DEPTH]);
                    checkData(i - PIPE_DEPTH, wbData, tblExpData[i - PIPE_DEPTH]);
                end
            end
            if (i < NUM_ENTRIES) begin
                instrValid = tblValid[i];
                instr      = tblInstr[i];
            end else begin
                instrValid = 1'b0;
                instr      = '0;
            end
        end

        $display("Errors: wbValid %0d, wbRd %0d, wbData %0d, other %0d",
                 validErrors, rdErrors, dataErrors, otherErrors);
        if (validErrors + rdErrors + dataErrors + otherErrors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("Timeout: the test did not finish within %0d time units", TIMEOUT);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
common/riscvPkg.sv
common/idExIf.sv
decode/regFile.sv
decode/decodeStage.sv
execute/alu.sv
execute/forwardUnit.sv
execute/execStage.sv
logic/writebackStage.sv
logic/riscvCore.sv
tb/tbRiscvCore.sv

/* run.sh */
#!/bin/sh
# Build the RV32I core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    -f flist.f \
    --top-module tbRiscvCore \
    --Mdir obj_dir -o simv

output=$(./obj_dir/simv)
echo "$output"

if echo "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi
